// File: design/enigma_pkg.sv
/*
  Shared widths, table sizes and word types for the six-bit rotor cipher.
  Modules import this package inside their bodies and name its types by scope in port lists.
*/

package enigma_pkg;

  // ==================================================
  // symbol and table geometry
  // ==================================================

  localparam int SYM_W = 6;

  // plaintext, table entries, ciphertext and rotor offset all share this width
  typedef logic [SYM_W-1:0] sym_t;

  localparam int ROTOR_SLOTS = 64;
  localparam int PLUG_SLOTS  = 32;

  // whitening state after reset
  localparam sym_t LFSR_SEED = sym_t'(1);

  // ==================================================
  // FIFO word
  // ==================================================

  // kind bit on top, set for a rotor-load word, clear for plaintext
  localparam int KIND_BIT = SYM_W;

  typedef logic [SYM_W:0] fifo_word_t;

endpackage

// File: design/enigma_plugboard_stage.sv
/*
  Producer stage. Registers each beat, keeps the plugboard pairing table and
  pushes plugboard-swapped plaintext and rotor-load words into the symbol FIFO.
*/

`timescale 1ns/1ns

module enigma_plugboard_stage (
  input  logic                   clk,
  input  logic                   srst_n,
  input  logic                   load,
  input  logic                   table_idx,
  input  logic                   encrypt,
  input  enigma_pkg::sym_t       code_in,
  output logic                   push,
  output enigma_pkg::fifo_word_t push_word
);

  import enigma_pkg::*;

  logic load_q;
  logic encrypt_q;
  logic table_idx_q;
  sym_t code_in_q;

  logic plug_load;
  logic rotor_load;
  sym_t swapped;

  sym_t plug_tbl [PLUG_SLOTS];

  // ==================================================
  // input register
  // ==================================================

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      load_q    <= 1'b0;
      encrypt_q <= 1'b0;
    end else begin
      load_q    <= load;
      encrypt_q <= encrypt;
    end
  end

  always_ff @(posedge clk) begin
    table_idx_q <= table_idx;
    code_in_q   <= code_in;
  end

  // table_idx 1 selects the plugboard, 0 the rotor
  assign plug_load  = load_q && table_idx_q;
  assign rotor_load = load_q && !table_idx_q;

  // ==================================================
  // pairing table
  // ==================================================

  // new symbol enters at slot 0, older ones move up
  always_ff @(posedge clk) begin
    if (plug_load) begin
      for (int i = PLUG_SLOTS - 1; i > 0; i--) begin
        plug_tbl[i] <= plug_tbl[i-1];
      end
      plug_tbl[0] <= code_in_q;
    end
  end

  // slots 2k and 2k+1 are partners
  // scanned from the top so the lowest matching slot is the last to write
  always_comb begin
    swapped = code_in_q;
    for (int k = PLUG_SLOTS / 2 - 1; k >= 0; k--) begin
      if (plug_tbl[2*k+1] == code_in_q) begin
        swapped = plug_tbl[2*k];
      end
      if (plug_tbl[2*k] == code_in_q) begin
        swapped = plug_tbl[2*k+1];
      end
    end
  end

  // ==================================================
  // push to FIFO
  // ==================================================

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      push <= 1'b0;
    end else begin
      push <= encrypt_q || rotor_load;
    end
  end

  // plaintext takes the swapped symbol, rotor loads carry the raw entry
  always_ff @(posedge clk) begin
    if (encrypt_q) begin
      push_word <= {1'b0, swapped};
    end else begin
      push_word <= {1'b1, code_in_q};
    end
  end

endmodule

// File: design/enigma_symbol_fifo.sv
/*
  Circular symbol buffer between the plugboard and rotor stages.
  Each pop hands one input credit back to the sender a cycle later.
*/

`timescale 1ns/1ns

module enigma_symbol_fifo #(
  parameter int BUF_DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   srst_n,
  input  logic                   push,
  input  enigma_pkg::fifo_word_t push_word,
  input  logic                   pop,
  output logic                   not_empty,
  output enigma_pkg::fifo_word_t head,
  output logic                   in_credit
);

  import enigma_pkg::*;

  localparam int PTR_W = $clog2(BUF_DEPTH);
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  fifo_word_t mem [BUF_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr];
  assign do_pop    = pop && not_empty;

  // sender credits bound occupancy, so a push always has room
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_word;
    end
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // one credit back per word consumed
  always_ff @(posedge clk) begin
    if (!srst_n) begin
      in_credit <= 1'b0;
    end else begin
      in_credit <= do_pop;
    end
  end

endmodule

// File: design/enigma_rotor_stage.sv
/*
  Consumer stage. Holds the rotor A table and its read offset, pops words from
  the symbol FIFO while output credits allow, and drives the whitened ciphertext.
*/

`timescale 1ns/1ns

module enigma_rotor_stage #(
  parameter int OUT_CREDITS = 2
) (
  input  logic                   clk,
  input  logic                   srst_n,
  input  logic                   not_empty,
  input  enigma_pkg::fifo_word_t head,
  input  logic                   out_credit,
  input  enigma_pkg::sym_t       mask,
  output logic                   pop,
  output logic                   lfsr_step,
  output logic                   code_valid,
  output enigma_pkg::sym_t       code_out
);

  import enigma_pkg::*;

  localparam int CNT_W = $clog2(OUT_CREDITS + 1);

  sym_t rotor_tbl [ROTOR_SLOTS];

  sym_t             offset;
  sym_t             head_sym;
  sym_t             rd_addr;
  sym_t             rotor_out;
  logic             head_is_load;
  logic             have_credit;
  logic             load_pop;
  logic             sym_pop;
  logic [CNT_W-1:0] credits;

  // ==================================================
  // pop decision
  // ==================================================

  assign head_is_load = head[KIND_BIT];
  assign head_sym     = head[SYM_W-1:0];
  assign have_credit  = (credits != '0);

  // rotor loads never wait for the receiver
  assign pop       = not_empty && (head_is_load || have_credit);
  assign load_pop  = pop && head_is_load;
  assign sym_pop   = pop && !head_is_load;
  assign lfsr_step = sym_pop;

  // ==================================================
  // rotor table and offset
  // ==================================================

  // newest entry at slot 63, after 64 loads slot i holds load i
  always_ff @(posedge clk) begin
    if (load_pop) begin
      for (int i = 0; i < ROTOR_SLOTS - 1; i++) begin
        rotor_tbl[i] <= rotor_tbl[i+1];
      end
      rotor_tbl[ROTOR_SLOTS-1] <= head_sym;
    end
  end

  // 6-bit add wraps mod 64
  assign rd_addr   = head_sym + offset;
  assign rotor_out = rotor_tbl[rd_addr];

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      offset <= '0;
    end else if (load_pop) begin
      offset <= offset + 1'b1;
    end else if (sym_pop) begin
      // advance by the low two bits of the unmasked output
      offset <= offset + sym_t'(rotor_out[1:0]);
    end
  end

  // ==================================================
  // output and credits
  // ==================================================

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      code_valid <= 1'b0;
    end else begin
      code_valid <= sym_pop;
    end
  end

  // mask is the LFSR state before this symbol's step
  always_ff @(posedge clk) begin
    if (sym_pop) begin
      code_out <= rotor_out ^ mask;
    end
  end

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      credits <= CNT_W'(OUT_CREDITS);
    end else begin
      case ({sym_pop, out_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

// File: design/enigma_whitening_lfsr.sv
/*
  Six-bit LFSR that supplies the XOR whitening mask.
  Steps once for every symbol the rotor stage emits.
*/

`timescale 1ns/1ns

module enigma_whitening_lfsr (
  input  logic             clk,
  input  logic             srst_n,
  input  logic             lfsr_step,
  output enigma_pkg::sym_t mask
);

  import enigma_pkg::*;

  sym_t state;
  logic feedback;

  // taps at the two top bits
  assign feedback = state[SYM_W-1] ^ state[SYM_W-2];

  always_ff @(posedge clk) begin
    if (!srst_n) begin
      state <= LFSR_SEED;
    end else if (lfsr_step) begin
      state <= {state[SYM_W-2:0], feedback};
    end
  end

  assign mask = state;

endmodule

// File: design/enigma_top.sv
/*
  Top level of the six-bit rotor cipher with credit flow control.
  Plugboard stage feeds a symbol FIFO that the rotor stage drains under output credits.
*/

`timescale 1ns/1ns

module enigma_top #(
  parameter int BUF_DEPTH   = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic             clk,
  input  logic             srst_n,
  input  logic             load,
  input  logic             table_idx,
  input  logic             encrypt,
  input  enigma_pkg::sym_t code_in,
  input  logic             out_credit,
  output logic             code_valid,
  output enigma_pkg::sym_t code_out,
  output logic             in_credit
);

  import enigma_pkg::*;

  logic       push;
  fifo_word_t push_word;
  logic       pop;
  logic       not_empty;
  fifo_word_t head;
  logic       lfsr_step;
  sym_t       mask;

  // ==================================================
  // producer, buffer, consumer
  // ==================================================

  enigma_plugboard_stage u_plugboard_stage (
    .clk       (clk),
    .srst_n    (srst_n),
    .load      (load),
    .table_idx (table_idx),
    .encrypt   (encrypt),
    .code_in   (code_in),
    .push      (push),
    .push_word (push_word)
  );

  enigma_symbol_fifo #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_symbol_fifo (
    .clk       (clk),
    .srst_n    (srst_n),
    .push      (push),
    .push_word (push_word),
    .pop       (pop),
    .not_empty (not_empty),
    .head      (head),
    .in_credit (in_credit)
  );

  enigma_rotor_stage #(
    .OUT_CREDITS (OUT_CREDITS)
  ) u_rotor_stage (
    .clk        (clk),
    .srst_n     (srst_n),
    .not_empty  (not_empty),
    .head       (head),
    .out_credit (out_credit),
    .mask       (mask),
    .pop        (pop),
    .lfsr_step  (lfsr_step),
    .code_valid (code_valid),
    .code_out   (code_out)
  );

  // whitening mask
  enigma_whitening_lfsr u_whitening_lfsr (
    .clk       (clk),
    .srst_n    (srst_n),
    .lfsr_step (lfsr_step),
    .mask      (mask)
  );

endmodule

// File: testbench/enigma_model.svh
/*
  Shadow model of the rotor cipher for the testbench. Included inside the
  testbench module, it follows plugboard, rotor, offset and whitening state
  beat by beat and queues the ciphertext it expects.
*/

`ifndef ENIGMA_MODEL_SVH
`define ENIGMA_MODEL_SVH

sym_t plug_shadow [PLUG_SLOTS];
sym_t rotor_shadow [ROTOR_SLOTS];
sym_t offset_shadow;
sym_t lfsr_shadow;
sym_t expected_q [$];

task automatic reset_shadow_state();
  for (int i = 0; i < PLUG_SLOTS; i++) begin
    plug_shadow[i] = '0;
  end
  for (int i = 0; i < ROTOR_SLOTS; i++) begin
    rotor_shadow[i] = '0;
  end
  offset_shadow = '0;
  // whitening starts from one
  lfsr_shadow = sym_t'(1);
  expected_q.delete();
endtask

// newest symbol lands in slot 0
task automatic shift_plug_shadow(input sym_t sym);
  for (int i = PLUG_SLOTS - 1; i > 0; i--) begin
    plug_shadow[i] = plug_shadow[i-1];
  end
  plug_shadow[0] = sym;
endtask

// newest entry lands in slot 63, each load steps the offset
task automatic shift_rotor_shadow(input sym_t sym);
  for (int i = 0; i < ROTOR_SLOTS - 1; i++) begin
    rotor_shadow[i] = rotor_shadow[i+1];
  end
  rotor_shadow[ROTOR_SLOTS-1] = sym;
  offset_shadow = offset_shadow + 6'd1;
endtask

// lowest matching slot wins, partner of slot i is slot i^1
function automatic sym_t swap_pair(input sym_t x);
  sym_t result;
  bit   found;
  result = x;
  found  = 1'b0;
  for (int i = 0; i < PLUG_SLOTS; i++) begin
    if (!found && plug_shadow[i] == x) begin
      result = plug_shadow[i ^ 1];
      found  = 1'b1;
    end
  end
  return result;
endfunction

task automatic predict_cipher(input sym_t x);
  sym_t paired;
  sym_t addr;
  sym_t rotor_val;
  paired    = swap_pair(x);
  addr      = paired + offset_shadow;
  rotor_val = rotor_shadow[addr];
  offset_shadow = offset_shadow + {4'b0000, rotor_val[1:0]};
  expected_q.push_back(rotor_val ^ lfsr_shadow);
  lfsr_shadow = {lfsr_shadow[4:0], lfsr_shadow[5] ^ lfsr_shadow[4]};
endtask

`endif

// File: testbench/enigma_tb.sv
/*
  Testbench for the rotor cipher top level. Loads plugboard and rotor tables,
  encrypts symbols under input and output credits and checks every result
  against the shadow model with immediate assertions.
*/

`timescale 1ns/1ns

module enigma_tb;

  import enigma_pkg::*;

  localparam int BUF_DEPTH   = 4;
  localparam int OUT_CREDITS = 2;
  // about 230 beats, credit stalls and an 80 cycle hold, well under a thousand cycles
  localparam int MAX_CYCLES  = 5000;
  localparam int PATTERN_LEN = 256;

  logic clk        = 1'b0;
  logic out_credit = 1'b0;
  logic srst_n;
  logic load;
  logic table_idx;
  logic encrypt;
  sym_t code_in;
  logic code_valid;
  sym_t code_out;
  logic in_credit;

  integer      seed;
  logic [31:0] rnd;
  logic        credit_pattern [PATTERN_LEN];
  logic        withhold;
  logic        credit_next    = 1'b0;
  int          costed_sent    = 0;
  int          credits_seen   = 0;
  int          port_beats     = 0;
  int          held_credits   = OUT_CREDITS;
  int          checked_count  = 0;
  int          returned_count = 0;
  int          rx_tick        = 0;
  int          cycle_count    = 0;
  sym_t        perm [ROTOR_SLOTS];

  `include "enigma_model.svh"

  enigma_top #(
    .BUF_DEPTH   (BUF_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) u_enigma_top (
    .clk        (clk),
    .srst_n     (srst_n),
    .load       (load),
    .table_idx  (table_idx),
    .encrypt    (encrypt),
    .code_in    (code_in),
    .out_credit (out_credit),
    .code_valid (code_valid),
    .code_out   (code_out),
    .in_credit  (in_credit)
  );

  always #5 clk = ~clk;

  // ==================================================
  // failure reporting and timeout
  // ==================================================

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input sym_t expected, input sym_t actual);
    $display("Error: %s expected 0x%h, got 0x%h", name, expected, actual);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  always @(posedge clk) begin
    cycle_count++;
    assert (cycle_count < MAX_CYCLES)
      else stop_with_failure("timeout: the run did not finish within the cycle limit");
  end

  // ==================================================
  // sender
  // ==================================================

  function automatic int sender_credits();
    return BUF_DEPTH - costed_sent + credits_seen;
  endfunction

  // encrypt beats and rotor loads cost a credit, plugboard loads are free
  task automatic send_beat(input logic l, input logic idx, input logic e, input sym_t sym);
    logic costed;
    costed = e || (l && !idx);
    @(posedge clk);
    #1;
    while (costed && sender_credits() == 0) begin
      load    = 1'b0;
      encrypt = 1'b0;
      @(posedge clk);
      #1;
    end
    load      = l;
    table_idx = idx;
    encrypt   = e;
    code_in   = sym;
    if (costed) begin
      costed_sent++;
    end
    if (l && idx) begin
      shift_plug_shadow(sym);
    end else if (l) begin
      shift_rotor_shadow(sym);
    end
    if (e) begin
      predict_cipher(sym);
    end
  endtask

  task automatic wait_drained();
    @(posedge clk);
    #1;
    load    = 1'b0;
    encrypt = 1'b0;
    while (checked_count != expected_q.size()) begin
      @(posedge clk);
    end
  endtask

  // ==================================================
  // receiver and checks
  // ==================================================

  always @(posedge clk) begin
    #1;
    out_credit = credit_next;
  end

  always @(negedge clk) begin
    if (srst_n) begin
      // costed beats on the port against credits already returned
      if (encrypt || (load && !table_idx)) begin
        port_beats++;
        assert (port_beats - credits_seen <= BUF_DEPTH)
          else stop_with_failure("sender presented a beat without an input credit");
      end
      if (code_valid) begin
        assert (held_credits > 0)
          else stop_with_failure("code_valid pulsed with no output credit held");
        assert (checked_count < expected_q.size())
          else stop_with_failure("code_valid pulsed with no symbol outstanding");
        assert (code_out === expected_q[checked_count])
          else report_mismatch("code_out", expected_q[checked_count], code_out);
        checked_count++;
        held_credits--;
      end
      if (out_credit) begin
        held_credits++;
      end
      if (in_credit) begin
        credits_seen++;
        assert (credits_seen <= costed_sent)
          else stop_with_failure("in_credit returned more credits than beats sent");
      end
      // only hand back credits for symbols already received
      credit_next = !withhold && (checked_count > returned_count) && credit_pattern[rx_tick];
      if (credit_next) begin
        returned_count++;
      end
      rx_tick = (rx_tick + 1) % PATTERN_LEN;
    end
  end

  // ==================================================
  // test sequence
  // ==================================================

  initial begin
    int   pick;
    sym_t tmp;
    seed      = 68794;
    srst_n    = 1'b0;
    load      = 1'b0;
    table_idx = 1'b0;
    encrypt   = 1'b0;
    code_in   = '0;
    withhold  = 1'b0;
    reset_shadow_state();
    // credit return pattern, about three cycles in four
    for (int i = 0; i < PATTERN_LEN; i++) begin
      rnd = $random(seed);
      credit_pattern[i] = (rnd[1:0] != 2'b00);
    end
    repeat (2) @(posedge clk);
    #1;
    srst_n = 1'b1;

    // quiet outputs after reset
    repeat (4) begin
      @(negedge clk);
      assert (code_valid === 1'b0)
        else report_mismatch("code_valid", 6'h00, sym_t'(code_valid));
      assert (in_credit === 1'b0)
        else report_mismatch("in_credit", 6'h00, sym_t'(in_credit));
    end

    // known pairs, identity rotor, matched and unmatched symbols
    for (int j = 0; j < PLUG_SLOTS; j++) begin
      send_beat(1'b1, 1'b1, 1'b0, sym_t'(j * 5 + 3));
    end
    for (int i = 0; i < ROTOR_SLOTS; i++) begin
      send_beat(1'b1, 1'b0, 1'b0, sym_t'(i));
    end
    for (int i = 0; i < 16; i++) begin
      send_beat(1'b0, 1'b0, 1'b1, sym_t'(i * 7));
    end
    wait_drained();

    // random permutation in the rotor
    for (int i = 0; i < ROTOR_SLOTS; i++) begin
      perm[i] = sym_t'(i);
    end
    for (int i = ROTOR_SLOTS - 1; i > 0; i--) begin
      rnd  = $random(seed);
      pick = rnd % (i + 1);
      tmp  = perm[i];
      perm[i]    = perm[pick];
      perm[pick] = tmp;
    end
    for (int i = 0; i < ROTOR_SLOTS; i++) begin
      send_beat(1'b1, 1'b0, 1'b0, perm[i]);
    end
    for (int i = 0; i < 40; i++) begin
      rnd = $random(seed);
      send_beat(1'b0, 1'b0, 1'b1, rnd[5:0]);
    end
    wait_drained();

    // receiver holds its credits, so the FIFO fills and the sender stalls
    withhold = 1'b1;
    fork
      begin
        for (int i = 0; i < 12; i++) begin
          rnd = $random(seed);
          send_beat(1'b0, 1'b0, 1'b1, rnd[5:0]);
        end
      end
      begin
        repeat (80) @(posedge clk);
        withhold = 1'b0;
      end
    join
    wait_drained();

    // last symbol and its input credit come back in the same cycle
    assert (sender_credits() == BUF_DEPTH)
      else stop_with_failure("input credits still missing after the FIFO drained");
    // quiet window for stray credits or outputs
    repeat (4) @(posedge clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: project.f
+incdir+testbench
design/enigma_pkg.sv
design/enigma_plugboard_stage.sv
design/enigma_symbol_fifo.sv
design/enigma_rotor_stage.sv
design/enigma_whitening_lfsr.sv
design/enigma_top.sv
testbench/enigma_tb.sv

// File: Makefile
# Verilator build and run of the rotor cipher testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal
TOP       := enigma_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

# the run exits nonzero when the testbench stops on $$fatal
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
